//--- logic/core_pkg.sv
// shared rv64 core types; only add, sub, and, or, xor, addi, lui, ld and sd are decoded.
`default_nettype none

package core_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [63:0] pc_t;
  typedef logic [4:0] reg_addr_t;

  // which stage's data goes to the register file.
  typedef enum logic [1:0] {
    sel_none = 2'd0,
    sel_exe  = 2'd1,
    sel_mem  = 2'd2
  } res_sel_e;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    alu_lui = 3'd5
  } alu_op_e;

  localparam logic [6:0] op_reg   = 7'b0110011;
  localparam logic [6:0] op_imm   = 7'b0010011;
  localparam logic [6:0] op_lui   = 7'b0110111;
  localparam logic [6:0] op_load  = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;

  localparam logic [2:0] f3_add   = 3'b000; // add, sub, addi.
  localparam logic [2:0] f3_xor   = 3'b100;
  localparam logic [2:0] f3_or    = 3'b110;
  localparam logic [2:0] f3_and   = 3'b111;
  localparam logic [2:0] f3_dword = 3'b011; // ld and sd.

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_sub  = 7'b0100000;

  // pc, inst, rs1, rs2, alu op, imm, store data, rd, wen, result select.
  localparam int dec_to_ex_width = $bits(pc_t) + $bits(inst_t) + 4 * $bits(xlen_t)
                                 + $bits(alu_op_e) + $bits(reg_addr_t) + 1 + $bits(res_sel_e);
  // pc, inst, alu result, store data, rd, wen, result select, store flag.
  localparam int ex_to_mem_width = $bits(pc_t) + $bits(inst_t) + 2 * $bits(xlen_t)
                                 + $bits(reg_addr_t) + 1 + $bits(res_sel_e) + 1;
  // pc, inst, exe data, mem data, rd, wen, result select.
  localparam int mem_to_wb_width = $bits(pc_t) + $bits(inst_t) + 2 * $bits(xlen_t)
                                 + $bits(reg_addr_t) + 1 + $bits(res_sel_e);

  // lsb of the alu result inside the ex_to_mem payload.
  localparam int ex_mem_addr_lsb = $bits(xlen_t) + $bits(reg_addr_t) + 1 + $bits(res_sel_e) + 1;

endpackage

`default_nettype wire

//--- logic/pipe_if.sv
// stage link with valid/allowin handshake; a transfer happens on an edge where both are high.
`timescale 1ns/10ps
`default_nettype none

interface pipe_if #(
  parameter int width = 1
) ();

  logic valid;             // upstream holds a payload.
  logic allowin;           // downstream takes it this edge.
  logic [width-1:0] bus;   // stage payload.

  // upstream side.
  modport src (
    output valid,
    output bus,
    input  allowin
  );

  // downstream side.
  modport dst (
    input  valid,
    input  bus,
    output allowin
  );

endinterface

`default_nettype wire

//--- logic/reg_file.sv
// 32x64 register file, x0 reads zero, same-cycle write bypassed to both reads; no reset of contents.
`timescale 1ns/10ps
`default_nettype none

module reg_file import core_pkg::*; (
  input  logic      clk,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output xlen_t     rs1_data,
  output xlen_t     rs2_data,
  input  logic      reg_wr_ena,
  input  reg_addr_t reg_wr_addr,
  input  xlen_t     reg_wr_data
);

  xlen_t regs [32];

  logic wr_live; // a real write this cycle.
  assign wr_live = reg_wr_ena && (reg_wr_addr != '0);

  always_ff @(posedge clk) begin
    if (wr_live) begin
      regs[reg_wr_addr] <= reg_wr_data;
    end
  end

  // x0 first, then the write in flight, then the array.
  always_comb begin
    if (rs1_addr == '0) rs1_data = '0;
    else if (wr_live && reg_wr_addr == rs1_addr) rs1_data = reg_wr_data;
    else rs1_data = regs[rs1_addr];

    if (rs2_addr == '0) rs2_data = '0;
    else if (wr_live && reg_wr_addr == rs2_addr) rs2_data = reg_wr_data;
    else rs2_data = regs[rs2_addr];
  end

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
// decode stage; no forwarding, an instruction waits until no later stage still writes its sources.
`timescale 1ns/10ps
`default_nettype none

module decode_stage import core_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      inst_valid,
  input  inst_t     inst,
  input  pc_t       inst_pc,
  output logic      inst_allowin,
  pipe_if.src       to_ex,
  input  logic      ex_wen,
  input  logic      mem_wen,
  input  logic      wb_wen,
  input  reg_addr_t ex_rd,
  input  reg_addr_t mem_rd,
  input  reg_addr_t wb_rd,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  input  xlen_t     rs1_data,
  input  xlen_t     rs2_data
);

  logic      dec_valid;
  pc_t       dec_pc;
  inst_t     dec_inst;
  logic      hazard;
  logic      rs1_hit, rs2_hit;
  logic      use_rs1, use_rs2;
  alu_op_e   alu_op;
  xlen_t     imm;
  logic      wen;
  reg_addr_t rd;
  res_sel_e  res_sel;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else if (inst_allowin) begin
      dec_valid <= inst_valid;
    end
    if (inst_valid && inst_allowin) begin
      dec_pc   <= inst_pc;
      dec_inst <= inst;
    end
  end

  assign rs1_addr = dec_inst[19:15];
  assign rs2_addr = dec_inst[24:20];

  always_comb begin
    alu_op  = alu_add;
    imm     = '0;
    wen     = 1'b0;
    res_sel = sel_none;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (dec_inst[6:0])
      op_reg: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        wen     = 1'b1;
        res_sel = sel_exe;
        if (dec_inst[31:25] == f7_sub && dec_inst[14:12] == f3_add) alu_op = alu_sub;
        else if (dec_inst[31:25] != f7_base) wen = 1'b0;
        else if (dec_inst[14:12] == f3_xor) alu_op = alu_xor;
        else if (dec_inst[14:12] == f3_or) alu_op = alu_or;
        else if (dec_inst[14:12] == f3_and) alu_op = alu_and;
        else if (dec_inst[14:12] != f3_add) wen = 1'b0;
      end
      op_imm: begin
        use_rs1 = 1'b1;
        imm     = {{52{dec_inst[31]}}, dec_inst[31:20]};
        wen     = (dec_inst[14:12] == f3_add); // addi only.
        res_sel = sel_exe;
      end
      op_lui: begin
        alu_op  = alu_lui;
        imm     = {{32{dec_inst[31]}}, dec_inst[31:12], 12'b0};
        wen     = 1'b1;
        res_sel = sel_exe;
      end
      op_load: begin
        use_rs1 = 1'b1;
        imm     = {{52{dec_inst[31]}}, dec_inst[31:20]};
        wen     = (dec_inst[14:12] == f3_dword);
        res_sel = sel_mem;
      end
      op_store: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm     = {{52{dec_inst[31]}}, dec_inst[31:25], dec_inst[11:7]};
      end
      default: ;    // anything else retires as a no-op.
    endcase
    if (dec_inst[11:7] == '0) wen = 1'b0;
    if (!wen) res_sel = sel_none;
    rd = wen ? dec_inst[11:7] : '0; // rd reads zero whenever nothing is written.
  end

  // read-after-write against every instruction still in flight.
  assign rs1_hit = use_rs1 && (rs1_addr != '0) && ((ex_wen && ex_rd == rs1_addr)
                 || (mem_wen && mem_rd == rs1_addr) || (wb_wen && wb_rd == rs1_addr));
  assign rs2_hit = use_rs2 && (rs2_addr != '0) && ((ex_wen && ex_rd == rs2_addr)
                 || (mem_wen && mem_rd == rs2_addr) || (wb_wen && wb_rd == rs2_addr));
  assign hazard  = dec_valid && (rs1_hit || rs2_hit);

  assign to_ex.valid  = dec_valid && !hazard; // a bubble while stalled.
  assign inst_allowin = !dec_valid || (!hazard && to_ex.allowin);
  assign to_ex.bus    = {dec_pc, dec_inst, rs1_data, rs2_data, alu_op, imm, rs2_data,
                         rd, wen, res_sel};

endmodule

`default_nettype wire

//--- logic/exec_stage.sv
// execute stage with the alu and address adder; always accepts, so it never back-pressures decode.
`timescale 1ns/10ps
`default_nettype none

module exec_stage import core_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  pipe_if.dst       from_dec,
  pipe_if.src       to_mem,
  output logic      ex_wen,
  output reg_addr_t ex_rd
);

  logic                       ex_valid;
  logic [dec_to_ex_width-1:0] ex_bus;

  pc_t                         ex_pc;
  inst_t                       ex_inst;
  xlen_t                       src1, src2;
  xlen_t                       imm;
  xlen_t                       st_data;
  logic [$bits(alu_op_e)-1:0]  op_bits;
  logic [$bits(res_sel_e)-1:0] sel_bits;
  reg_addr_t                   rd;
  logic                        wen;
  alu_op_e                     alu_op;
  logic                        use_imm;
  logic                        is_store;
  xlen_t                       op_b;
  xlen_t                       alu_res;

  assign from_dec.allowin = 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (from_dec.allowin) begin
      ex_valid <= from_dec.valid;
    end
    if (from_dec.valid && from_dec.allowin) begin
      ex_bus <= from_dec.bus;
    end
  end

  assign {ex_pc, ex_inst, src1, src2, op_bits, imm, st_data, rd, wen, sel_bits} = ex_bus;
  assign alu_op = alu_op_e'(op_bits);

  // addi, ld and sd add the immediate to rs1.
  assign use_imm  = (ex_inst[6:0] == op_imm) || (ex_inst[6:0] == op_load)
                  || (ex_inst[6:0] == op_store);
  assign is_store = (ex_inst[6:0] == op_store) && (ex_inst[14:12] == f3_dword);
  assign op_b     = use_imm ? imm : src2;

  always_comb begin
    case (alu_op)
      alu_add: alu_res = src1 + op_b;
      alu_sub: alu_res = src1 - op_b;
      alu_and: alu_res = src1 & op_b;
      alu_or:  alu_res = src1 | op_b;
      alu_xor: alu_res = src1 ^ op_b;
      alu_lui: alu_res = imm;      // already shifted and sign-extended.
      default: alu_res = '0;
    endcase
  end

  assign to_mem.valid = ex_valid;
  assign to_mem.bus   = {ex_pc, ex_inst, alu_res, st_data, rd, wen, sel_bits, is_store};

  assign ex_wen = ex_valid && wen; // pending write for the hazard check.
  assign ex_rd  = rd;

endmodule

`default_nettype wire

//--- logic/mem_stage.sv
// memory stage; doubleword ram indexed by address bits 3 up modulo dmem_words, low bits ignored.
`timescale 1ns/10ps
`default_nettype none

module mem_stage import core_pkg::*; #(
  parameter int dmem_words = 256
) (
  input  logic      clk,
  input  logic      rst,
  pipe_if.dst       from_ex,
  pipe_if.src       to_wb,
  output logic      mem_wen,
  output reg_addr_t mem_rd
);

  localparam int idx_w = (dmem_words > 1) ? $clog2(dmem_words) : 1;

  xlen_t dmem [dmem_words];

  logic                        mem_valid;
  logic [ex_to_mem_width-1:0]  mem_bus;
  pc_t                         mem_pc;
  inst_t                       mem_inst;
  xlen_t                       exe_data;
  xlen_t                       st_data;
  reg_addr_t                   rd;
  logic                        wen;
  logic [$bits(res_sel_e)-1:0] sel_bits;
  logic                        is_store;
  xlen_t                       ld_data;
  logic [idx_w-1:0]            idx_in, idx_cur;
  logic                        wr_fire;

  assign from_ex.allowin = 1'b1;

  assign {mem_pc, mem_inst, exe_data, st_data, rd, wen, sel_bits, is_store} = mem_bus;

  assign idx_in  = from_ex.bus[ex_mem_addr_lsb + 3 +: idx_w]; // incoming address.
  assign idx_cur = exe_data[3 +: idx_w];
  assign wr_fire = mem_valid && is_store && to_wb.allowin;     // sd leaving for write-back.

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid <= 1'b0;
    end else if (from_ex.allowin) begin
      mem_valid <= from_ex.valid;
    end
  end

  // the read is taken as the load comes in, so a store leaving on that edge is passed across.
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      dmem[idx_cur] <= st_data;
    end
    if (from_ex.valid && from_ex.allowin) begin
      mem_bus <= from_ex.bus;
      if (wr_fire && idx_cur == idx_in) ld_data <= st_data;
      else ld_data <= dmem[idx_in];
    end
  end

  assign to_wb.valid = mem_valid;
  assign to_wb.bus   = {mem_pc, mem_inst, exe_data, ld_data, rd, wen, sel_bits};

  assign mem_wen = mem_valid && wen;
  assign mem_rd  = rd;

endmodule

`default_nettype wire

//--- logic/wb_stage.sv
// write-back stage; commit ports report each retired instruction once, data is zero without a write.
`timescale 1ns/10ps
`default_nettype none

module wb_stage import core_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  pipe_if.dst       from_mem,
  output logic      reg_wr_ena,
  output reg_addr_t reg_wr_addr,
  output xlen_t     reg_wr_data,
  output logic      wb_wen,
  output reg_addr_t wb_rd,
  output logic      commit_valid,
  output pc_t       commit_pc,
  output inst_t     commit_inst,
  output logic      commit_wen,
  output reg_addr_t commit_rd,
  output xlen_t     commit_data
);

  logic                        wb_valid;
  logic [mem_to_wb_width-1:0]  wb_bus;
  pc_t                         wb_pc;
  inst_t                       wb_inst;
  xlen_t                       exe_data, mem_data;
  reg_addr_t                   rd;
  logic                        wen;
  logic [$bits(res_sel_e)-1:0] sel_bits;
  res_sel_e                    res_sel;

  assign from_mem.allowin = 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else if (from_mem.allowin) begin
      wb_valid <= from_mem.valid;
    end
    if (from_mem.valid && from_mem.allowin) begin
      wb_bus <= from_mem.bus;
    end
  end

  // everything reads zero while the stage is empty.
  assign {wb_pc, wb_inst, exe_data, mem_data, rd, wen, sel_bits} =
         wb_bus & {mem_to_wb_width{wb_valid}};
  assign res_sel = res_sel_e'(sel_bits);

  assign reg_wr_ena  = wen && wb_valid;
  assign reg_wr_addr = rd;
  assign reg_wr_data = (res_sel == sel_mem) ? mem_data :
                       (res_sel == sel_exe) ? exe_data : '0;

  assign wb_wen = reg_wr_ena;
  assign wb_rd  = rd;

  assign commit_valid = wb_valid;
  assign commit_pc    = wb_pc;
  assign commit_inst  = wb_inst;
  assign commit_wen   = reg_wr_ena;
  assign commit_rd    = rd;
  assign commit_data  = reg_wr_ena ? reg_wr_data : '0;

endmodule

`default_nettype wire

//--- logic/rv_core_top.sv
// rv64 integer pipeline top; instructions come in with their pc, no fetch, branches or exceptions.
`timescale 1ns/10ps
`default_nettype none

module rv_core_top import core_pkg::*; #(
  parameter int dmem_words = 256 // data ram depth in doublewords, a power of two.
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      inst_valid,
  input  inst_t     inst,
  input  pc_t       inst_pc,
  output logic      inst_allowin,
  output logic      commit_valid,
  output pc_t       commit_pc,
  output inst_t     commit_inst,
  output logic      commit_wen,
  output reg_addr_t commit_rd,
  output xlen_t     commit_data
);

  pipe_if #(.width(dec_to_ex_width)) dec_to_ex ();
  pipe_if #(.width(ex_to_mem_width)) ex_to_mem ();
  pipe_if #(.width(mem_to_wb_width)) mem_to_wb ();

  logic      ex_wen, mem_wen, wb_wen;
  reg_addr_t ex_rd, mem_rd, wb_rd;
  reg_addr_t rs1_addr, rs2_addr;
  xlen_t     rs1_data, rs2_data;
  logic      reg_wr_ena;
  reg_addr_t reg_wr_addr;
  xlen_t     reg_wr_data;

  decode_stage u_decode (
    .clk, .rst, .inst_valid, .inst, .inst_pc, .inst_allowin,
    .to_ex (dec_to_ex),
    .ex_wen, .mem_wen, .wb_wen, .ex_rd, .mem_rd, .wb_rd,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data
  );

  exec_stage u_exec (
    .clk, .rst,
    .from_dec (dec_to_ex),
    .to_mem   (ex_to_mem),
    .ex_wen, .ex_rd
  );

  mem_stage #(.dmem_words(dmem_words)) u_mem (
    .clk, .rst,
    .from_ex (ex_to_mem),
    .to_wb   (mem_to_wb),
    .mem_wen, .mem_rd
  );

  wb_stage u_wb (
    .clk, .rst,
    .from_mem (mem_to_wb),
    .reg_wr_ena, .reg_wr_addr, .reg_wr_data, .wb_wen, .wb_rd,
    .commit_valid, .commit_pc, .commit_inst, .commit_wen, .commit_rd, .commit_data
  );

  reg_file u_reg_file (
    .clk, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .reg_wr_ena, .reg_wr_addr, .reg_wr_data
  );

endmodule

`default_nettype wire

//--- tests/rv_core_sva.sv
// assertions bound into rv_core_top; the stall check reaches into u_decode for the held instruction.
`timescale 1ns/10ps
`default_nettype none

module rv_core_sva import core_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      inst_allowin,
  input logic      commit_valid,
  input logic      commit_wen,
  input reg_addr_t commit_rd,
  input logic      dec_valid,
  input inst_t     dec_inst,
  input logic      ex_wen,
  input logic      mem_wen,
  input logic      wb_wen,
  input reg_addr_t ex_rd,
  input reg_addr_t mem_rd,
  input reg_addr_t wb_rd
);

  int fail_count = 0; // read by the testbench at the end of the run.

  reg_addr_t src1, src2;
  logic      reads1, reads2;
  logic      owed1, owed2;   // a later stage still writes this source.
  logic      raw_wait;

  assign src1   = dec_inst[19:15];
  assign src2   = dec_inst[24:20];
  assign reads1 = dec_inst[6:0] inside {op_reg, op_imm, op_load, op_store};
  assign reads2 = dec_inst[6:0] inside {op_reg, op_store};
  assign owed1  = (src1 != '0) && ((ex_wen && ex_rd == src1) || (mem_wen && mem_rd == src1)
                || (wb_wen && wb_rd == src1));
  assign owed2  = (src2 != '0) && ((ex_wen && ex_rd == src2) || (mem_wen && mem_rd == src2)
                || (wb_wen && wb_rd == src2));
  assign raw_wait = dec_valid && ((reads1 && owed1) || (reads2 && owed2));

  a_quiet_after_reset: assert property (@(posedge clk) rst |=> !commit_valid)
    else begin
      fail_count++;
      $error("commit_valid high in the cycle after reset");
    end

  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    commit_valid && commit_wen |-> commit_rd != '0)
    else begin
      fail_count++;
      $error("commit with wen set names x0");
    end

  // decode must not take a new instruction while it holds a stalled one.
  a_stall_blocks_input: assert property (@(posedge clk) disable iff (rst)
    raw_wait |-> !inst_allowin)
    else begin
      fail_count++;
      $error("inst_allowin high while decode waits on a pending write");
    end

endmodule

bind rv_core_top rv_core_sva u_sva (
  .clk, .rst, .inst_allowin, .commit_valid, .commit_wen, .commit_rd,
  .dec_valid (u_decode.dec_valid),
  .dec_inst  (u_decode.dec_inst),
  .ex_wen, .mem_wen, .wb_wen, .ex_rd, .mem_rd, .wb_rd
);

`default_nettype wire

//--- tests/rv_core_checker.sv
// in-order model of the rv64 subset; register and ram words never written by the program read as x.
`timescale 1ns/10ps
`default_nettype none

module rv_core_checker import core_pkg::*; #(
  parameter int dmem_words = 256
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      inst_valid,
  input  inst_t     inst,
  input  pc_t       inst_pc,
  input  logic      inst_allowin,
  input  logic      commit_valid,
  input  pc_t       commit_pc,
  input  inst_t     commit_inst,
  input  logic      commit_wen,
  input  reg_addr_t commit_rd,
  input  xlen_t     commit_data,
  input  logic      end_run,
  input  logic      timed_out,
  input  int        assert_errors,
  output int        error_count,
  output int        pending
);

  pc_t   pc_q [$];         // accepted, not yet committed.
  inst_t inst_q [$];
  xlen_t model_regs [32];
  xlen_t model_mem [int];  // keyed by doubleword index.
  int    mismatches = 0;
  int    others = 0;
  logic  rst_q = 1'b0;

  assign error_count = mismatches + others + assert_errors;

  initial begin
    model_regs[0] = '0;
    pending       = 0;
  end

  // executes one instruction on the model and returns what it should commit.
  function automatic void predict(input inst_t w, output logic wen, output reg_addr_t rd,
                                  output xlen_t data);
    xlen_t a;
    xlen_t b;
    xlen_t imm_i;
    logic  rr;
    int    idx;
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    imm_i = {{52{w[31]}}, w[31:20]};
    rr    = (w[6:0] == op_reg) && (w[31:25] == 7'h00);
    wen   = 1'b1;
    data  = '0;
    if (rr && w[14:12] == 3'b000) data = a + b;
    else if (w[6:0] == op_reg && w[31:25] == 7'h20 && w[14:12] == 3'b000) data = a - b;
    else if (rr && w[14:12] == 3'b111) data = a & b;
    else if (rr && w[14:12] == 3'b110) data = a | b;
    else if (rr && w[14:12] == 3'b100) data = a ^ b;
    else if (w[6:0] == op_imm && w[14:12] == 3'b000) data = a + imm_i;
    else if (w[6:0] == op_lui) data = {{32{w[31]}}, w[31:12], 12'h000};
    else if (w[6:0] == op_load && w[14:12] == 3'b011) begin
      idx  = int'(((a + imm_i) >> 3) % dmem_words);
      data = 'x;
      if (model_mem.exists(idx)) data = model_mem[idx];
    end else begin
      wen = 1'b0;
      if (w[6:0] == op_store && w[14:12] == 3'b011) begin
        idx            = int'(((a + {{52{w[31]}}, w[31:25], w[11:7]}) >> 3) % dmem_words);
        model_mem[idx] = b;
      end
    end
    rd = w[11:7];
    if (rd == '0) wen = 1'b0;
    if (wen) model_regs[rd] = data;
    else begin
      rd   = '0;
      data = '0;
    end
  endfunction

  task automatic compare_value(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  always @(posedge clk) begin : watch
    pc_t       exp_pc;
    inst_t     exp_inst;
    logic      exp_wen;
    reg_addr_t exp_rd;
    xlen_t     exp_data;
    rst_q <= rst;
    if (rst_q && !rst) begin // first edge out of reset.
      compare_value("inst_allowin", xlen_t'(inst_allowin), 64'h1);
      compare_value("commit_valid", xlen_t'(commit_valid), 64'h0);
    end
    if (!rst && commit_valid) begin
      if (pc_q.size() == 0) begin
        $display("a commit arrived with no instruction outstanding, pc %h", commit_pc);
        others++;
      end else begin
        exp_pc   = pc_q.pop_front();
        exp_inst = inst_q.pop_front();
        predict(exp_inst, exp_wen, exp_rd, exp_data);
        compare_value("commit_pc", commit_pc, exp_pc);
        compare_value("commit_inst", xlen_t'(commit_inst), xlen_t'(exp_inst));
        compare_value("commit_wen", xlen_t'(commit_wen), xlen_t'(exp_wen));
        compare_value("commit_rd", xlen_t'(commit_rd), xlen_t'(exp_rd));
        compare_value("commit_data", commit_data, exp_data);
      end
    end
    if (!rst && inst_valid && inst_allowin) begin
      pc_q.push_back(inst_pc);
      inst_q.push_back(inst);
    end
    pending = pc_q.size();
  end

  always @(posedge end_run) begin
    if (timed_out) begin
      $display("timeout: the core stopped accepting or committing instructions");
      others++;
    end
    if (pc_q.size() != 0) begin
      $display("%0d accepted instructions never committed", pc_q.size());
      others++;
    end
    $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
             mismatches, others, assert_errors);
  end

endmodule

`default_nettype wire

//--- tests/rv_core_tb.sv
// directed program then 400 seeded random instructions; random ld and sd use only ram words 0 to 15.
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb import core_pkg::*; ();

  localparam int dmem_words = 256;
  localparam int wait_limit = 200; // cycles allowed for any single wait.

  logic      clk = 1'b0;
  logic      rst;
  logic      inst_valid;
  inst_t     inst;
  pc_t       inst_pc;
  logic      inst_allowin, commit_valid, commit_wen;
  pc_t       commit_pc;
  inst_t     commit_inst;
  reg_addr_t commit_rd;
  xlen_t     commit_data;
  logic      end_run = 1'b0;
  logic      timed_out = 1'b0;
  int        error_count, pending;
  pc_t       next_pc = 64'h8000_0000;

  always #10 clk = ~clk;

  rv_core_top #(.dmem_words(dmem_words)) u_rv_core_top (.*);

  rv_core_checker #(.dmem_words(dmem_words)) u_checker (
    .*, .assert_errors (u_rv_core_top.u_sva.fail_count)
  );

  function automatic inst_t alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                   input int rd, rs1, rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op_reg};
  endfunction

  // i-type layout, used for addi, ld and the odd unsupported form.
  function automatic inst_t alu_ri(input logic [6:0] opc, input logic [2:0] f3,
                                   input int rd, rs1, imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic inst_t store_dw(input int rs2, rs1, imm);
    return {7'(imm >> 5), 5'(rs2), 5'(rs1), f3_dword, 5'(imm), op_store};
  endfunction

  function automatic inst_t lui_word(input int rd, imm20);
    return {20'(imm20), 5'(rd), op_lui};
  endfunction

  function automatic inst_t random_inst();
    int kind;
    int rd;
    int rs1;
    int rs2;
    kind = $urandom_range(0, 19);
    rd   = $urandom_range(0, 31);
    rs1  = $urandom_range(0, 31);
    rs2  = $urandom_range(0, 31);
    case (kind)
      0, 1:       return alu_rr(f7_base, f3_add, rd, rs1, rs2);
      2, 3:       return alu_rr(f7_sub, f3_add, rd, rs1, rs2);
      4:          return alu_rr(f7_base, f3_and, rd, rs1, rs2);
      5:          return alu_rr(f7_base, f3_or, rd, rs1, rs2);
      6:          return alu_rr(f7_base, f3_xor, rd, rs1, rs2);
      7, 8, 9:    return alu_ri(op_imm, f3_add, rd, rs1, $urandom_range(0, 4095));
      10, 11:     return lui_word(rd, $urandom);
      12, 13, 14: return alu_ri(op_load, f3_dword, rd, 0, $urandom_range(0, 127));
      15, 16, 17: return store_dw(rs2, 0, 8 * $urandom_range(0, 15));
      18:         return alu_rr(f7_base, 3'b001, rd, rs1, rs2); // sll is not decoded.
      default:    return alu_ri(7'b1100011, 3'b000, rd, rs1, $urandom_range(0, 4095));
    endcase
  endfunction

  // holds the word on the inputs until decode takes it.
  task automatic send(input inst_t word);
    int waited;
    waited = 0;
    if (!timed_out) begin
      inst_valid <= 1'b1;
      inst       <= word;
      inst_pc    <= next_pc;
      @(posedge clk);
      while (!inst_allowin && waited < wait_limit) begin
        waited++;
        @(posedge clk);
      end
      if (!inst_allowin) timed_out = 1'b1;
      inst_valid <= 1'b0;
      next_pc = next_pc + 4;
    end
  endtask

  initial begin
    int gap;
    int waited;
    void'($urandom(31580));
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    inst_pc    = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    repeat (3) @(posedge clk);
    for (int r = 1; r < 32; r++) begin // every addi waits on its own lui.
      send(lui_word(r, $urandom));
      send(alu_ri(op_imm, f3_add, r, r, $urandom_range(0, 4095)));
    end
    send(alu_rr(f7_base, f3_add, 10, 1, 2));
    send(alu_rr(f7_sub, f3_add, 11, 3, 4));
    send(alu_rr(f7_base, f3_and, 12, 5, 6));
    send(alu_rr(f7_base, f3_or, 13, 7, 8));
    send(alu_rr(f7_base, f3_xor, 14, 10, 11));
    send(alu_ri(op_imm, f3_add, 15, 15, -1));
    send(alu_ri(op_imm, f3_add, 16, 0, -2048));
    send(lui_word(17, 'h80000));
    send(lui_word(18, 'hfffff));
    send(alu_ri(op_imm, f3_add, 0, 1, 5));   // x0 keeps zero.
    send(alu_rr(f7_base, f3_add, 0, 1, 2));
    send(alu_rr(f7_base, f3_add, 19, 0, 0));
    for (int k = 0; k < 16; k++) send(store_dw(k + 1, 0, 8 * k));
    // x21 becomes 2048, one full ram span, so its offsets alias the low words.
    send(alu_ri(op_imm, f3_add, 21, 0, 1024));
    send(alu_rr(f7_base, f3_add, 21, 21, 21));
    send(store_dw(22, 0, 16));
    send(alu_ri(op_load, f3_dword, 23, 21, 16));
    send(alu_ri(op_load, f3_dword, 24, 0, 21));
    send(store_dw(25, 21, 29));
    send(alu_ri(op_load, f3_dword, 26, 0, 24));
    send(alu_rr(f7_base, f3_add, 27, 26, 23));
    send(32'h0000_0073);
    send(alu_ri(op_imm, 3'b010, 28, 1, 9));
    send(alu_ri(op_load, 3'b010, 29, 0, 8));
    send(alu_rr(f7_sub, f3_xor, 30, 1, 2));
    for (int n = 0; n < 400; n++) begin
      send(random_inst());
      gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;
      repeat (gap) @(posedge clk);
    end
    waited = 0;
    @(negedge clk);
    while (pending != 0 && waited < wait_limit) begin // drain the pipeline.
      waited++;
      @(negedge clk);
    end
    if (pending != 0) timed_out = 1'b1;
    end_run = 1'b1;
    #1;
    if (error_count == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
logic/core_pkg.sv
logic/pipe_if.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/rv_core_top.sv
tests/rv_core_sva.sv
tests/rv_core_checker.sv
tests/rv_core_tb.sv
